/* arrayMachine.f */
+incdir+verif
common/machinePkg.sv
src/fetchUnit.sv
execute/operandResolver.sv
execute/executeUnit.sv
src/dataMemory.sv
src/arrayAllocator.sv
src/arrayMachine.sv
verif/arrayMachineTb.sv

/* common/machinePkg.sv */
//--------------------
// Array machine package
// sizes, data types and instruction layout shared by all blocks
//--------------------
package machinePkg;

  //--------------------
  // sizes
  localparam int areaSize   = 4;                     // elements per array
  localparam int arrayCount = 4;
  localparam int heapSize   = areaSize * arrayCount;
  localparam int localSize  = 8;
  localparam int codeSize   = 32;                    // instruction slots

  localparam int wordW      = 16;
  localparam int areaW      = 8;                     // area and address fields
  localparam int heapAddrW  = $clog2(heapSize);
  localparam int localAddrW = $clog2(localSize);
  localparam int arrayNumW  = $clog2(arrayCount);
  localparam int codeAddrW  = $clog2(codeSize);

  //--------------------
  // vector types
  typedef logic signed [wordW-1:0]  word_t;
  typedef logic signed [areaW-1:0]  area_t;          // also the jump offset
  typedef logic [heapAddrW-1:0]     heapAddr_t;      // wraps modulo heapSize
  typedef logic [localAddrW-1:0]    localAddr_t;
  typedef logic [arrayNumW-1:0]     arrayNum_t;
  typedef logic [codeAddrW-1:0]     codeAddr_t;

  typedef word_t [heapSize-1:0]     heapImage_t;     // whole heap
  typedef word_t [localSize-1:0]    localImage_t;
  typedef word_t [arrayCount-1:0]   sizeImage_t;     // one size per array

  //--------------------
  // encodings
  typedef enum logic [1:0] {arenaNone = 2'd0, arenaHeap = 2'd1, arenaLocal = 2'd2} arena_t;
  typedef enum logic {areaDirect = 1'b0, areaIndirect = 1'b1} areaMode_t;
  typedef enum logic [1:0] {addrConst = 2'd0, addrDirect = 2'd1, addrIndirect = 2'd2} addrMode_t;

  typedef enum logic [7:0] {
    opAdd        = 8'd0,
    opArray      = 8'd1,
    opArraySize  = 8'd6,
    opFree       = 8'd19,
    opJEq        = 8'd22,
    opJFalse     = 8'd23,
    opJGe        = 8'd24,
    opJGt        = 8'd25,
    opJLe        = 8'd26,
    opJLt        = 8'd27,
    opJNe        = 8'd28,
    opJTrue      = 8'd29,
    opJmp        = 8'd30,
    opMov        = 8'd34,
    opNot        = 8'd37,
    opOut        = 8'd38,
    opResize     = 8'd48,
    opShiftLeft  = 8'd53,
    opShiftRight = 8'd54,
    opSubtract   = 8'd56
  } opcode_t;

  //--------------------
  // structs
  typedef struct packed {
    area_t      area;
    area_t      address;
    arena_t     arena;
    areaMode_t  areaMode;
    addrMode_t  addrMode;
    logic [3:0] delta;                               // unsigned offset
    logic [6:0] spare;
  } operand_t;                                       // 32 bits

  typedef struct packed {
    opcode_t  opcode;
    operand_t target;
    operand_t source1;
    operand_t source2;
  } instruction_t;                                   // 104 bits

  typedef struct packed {
    word_t      value;
    arena_t     arena;                               // arena as written
    area_t      area;                                // area as written, used by jumps
    heapAddr_t  heapLoc;
    localAddr_t localLoc;
    arrayNum_t  arrayNum;
    word_t      index;                               // index within the array
    logic       valid;                               // low for arenaNone
  } resolved_t;

  typedef struct packed {
    logic       enable;
    arena_t     arena;
    heapAddr_t  heapLoc;
    localAddr_t localLoc;
    arrayNum_t  arrayNum;
    word_t      index;
    word_t      data;
  } memWrite_t;

endpackage

/* execute/executeUnit.sv */
//--------------------
// Execute unit
// decodes the opcode, computes the result and raises the strobes
//--------------------
`timescale 1ns/100ps

module executeUnit (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    active,
  input  machinePkg::opcode_t     opcode,
  input  machinePkg::resolved_t   target,
  input  machinePkg::resolved_t   source1,
  input  machinePkg::resolved_t   source2,
  input  machinePkg::sizeImage_t  sizes,
  input  machinePkg::arrayNum_t   grant,
  output machinePkg::memWrite_t   memWrite,
  output logic                    resize,
  output machinePkg::arrayNum_t   resizeArray,
  output machinePkg::word_t       resizeValue,
  output logic                    jump,
  output machinePkg::area_t       jumpOffset,
  output logic                    allocate,
  output logic                    releaseEn,
  output machinePkg::arrayNum_t   releaseNum,
  output logic                    outValid,
  output machinePkg::word_t       outValue
);
  import machinePkg::*;

  word_t result;
  word_t sizeRead;
  logic  writes;
  logic  taken;
  logic  isOut;

  assign sizeRead = sizes[arrayNum_t'(source1.value)];

  always_comb begin
    result = '0;
    writes = 1'b0;
    taken  = 1'b0;
    isOut  = 1'b0;
    case (opcode)
      opAdd:        begin result = source1.value + source2.value; writes = 1'b1; end
      opSubtract:   begin result = source1.value - source2.value; writes = 1'b1; end
      opMov:        begin result = source1.value;                 writes = 1'b1; end
      opNot:        begin result = (source1.value == 0) ? 16'sd1 : 16'sd0; writes = 1'b1; end
      opShiftLeft:  begin result = target.value << source1.value; writes = 1'b1; end
      opShiftRight: begin result = target.value >> source1.value; writes = 1'b1; end
      opArray:      begin result = word_t'(grant);                writes = 1'b1; end
      opArraySize:  begin result = sizeRead;                      writes = 1'b1; end
      opOut:        isOut = 1'b1;
      opJEq:        taken = source1.value == source2.value;
      opJNe:        taken = source1.value != source2.value;
      opJLt:        taken = source1.value <  source2.value;
      opJLe:        taken = source1.value <= source2.value;
      opJGt:        taken = source1.value >  source2.value;
      opJGe:        taken = source1.value >= source2.value;
      opJTrue:      taken = source1.value != 0;
      opJFalse:     taken = source1.value == 0;
      opJmp:        taken = 1'b1;
      default:      ;                                // unknown opcodes do nothing
    endcase
  end

  //--------------------
  // strobes, all gated by active
  assign memWrite = '{enable:   active && writes && target.valid,
                      arena:    target.arena,
                      heapLoc:  target.heapLoc,
                      localLoc: target.localLoc,
                      arrayNum: target.arrayNum,
                      index:    target.index,
                      data:     result};

  assign resize      = active && (opcode == opResize);
  assign resizeArray = target.arrayNum;
  assign resizeValue = source1.value;
  assign jump        = active && taken;
  assign jumpOffset  = target.area;                  // signed step from this slot
  assign allocate    = active && (opcode == opArray);
  assign releaseEn   = active && (opcode == opFree);
  assign releaseNum  = arrayNum_t'(target.value);

  always_ff @(posedge clock) begin
    if (rst) outValid <= 1'b0;
    else     outValid <= active && isOut;            // one pulse per out
  end

  always_ff @(posedge clock) begin
    if (active && isOut) outValue <= source1.value;
  end

  // a taken jump with no step would spin forever
  assert property (@(posedge clock) disable iff (rst) jump |-> jumpOffset != '0)
    else $error("taken jump with zero offset");

endmodule

/* execute/operandResolver.sv */
//--------------------
// Operand resolver
// applies arena, area and address modes plus delta to one operand
//--------------------
`timescale 1ns/100ps

module operandResolver (
  input  machinePkg::operand_t    operand,
  input  machinePkg::localImage_t localImage,
  input  machinePkg::heapImage_t  heapImage,
  output machinePkg::resolved_t   resolved
);
  import machinePkg::*;

  arrayNum_t  areaNum;
  word_t      areaWord;
  word_t      addrBase;
  word_t      index;
  heapAddr_t  heapLoc;
  localAddr_t localLoc;

  always_comb begin
    areaWord = localImage[localAddr_t'(operand.area)];
    areaNum  = (operand.areaMode == areaIndirect) ? arrayNum_t'(areaWord)
                                                  : arrayNum_t'(operand.area);
    if (operand.addrMode == addrIndirect) begin
      addrBase = localImage[localAddr_t'(operand.address)];
    end else begin
      addrBase = word_t'(operand.address);           // sign extended
    end
    index    = word_t'(operand.delta) + addrBase;
    heapLoc  = heapAddr_t'(areaSize * int'(areaNum) + int'(index));
    localLoc = localAddr_t'(index);
  end

  always_comb begin
    resolved.arena    = operand.arena;
    resolved.area     = operand.area;
    resolved.heapLoc  = heapLoc;
    resolved.localLoc = localLoc;
    resolved.arrayNum = areaNum;
    resolved.index    = index;
    resolved.valid    = (operand.arena == arenaHeap) || (operand.arena == arenaLocal);
    case (operand.arena)
      arenaHeap: begin
        resolved.value = (operand.addrMode == addrConst) ? word_t'(operand.address)
                                                         : heapImage[heapLoc];
      end
      arenaLocal: begin
        resolved.value = (operand.addrMode == addrConst) ? word_t'(operand.address)
                                                         : localImage[localLoc];
      end
      default: resolved.value = '0;                  // no arena reads as zero
    endcase
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the array machine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module arrayMachineTb -f arrayMachine.f
simOut=$(./obj_dir/VarrayMachineTb)
echo "$simOut"

if grep -q "^TEST PASS$" <<< "$simOut"; then
  exit 0
fi
exit 1

/* src/arrayAllocator.sv */
//--------------------
// Array allocator
// hands out new array numbers and reuses freed ones first
//--------------------
`timescale 1ns/100ps

module arrayAllocator (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  allocate,
  input  logic                  releaseEn,
  input  machinePkg::arrayNum_t releaseNum,
  output machinePkg::arrayNum_t grant
);
  import machinePkg::*;

  arrayNum_t          freedStack [arrayCount];
  logic [arrayNumW:0] stackTop;                      // entries on the stack
  logic [arrayNumW:0] allocCount;                    // never allocated before

  assign grant = (stackTop != '0) ? freedStack[arrayNum_t'(stackTop - 1'b1)]
                                  : arrayNum_t'(allocCount);

  always_ff @(posedge clock) begin
    if (rst) begin
      stackTop   <= '0;
      allocCount <= '0;
    end else if (allocate) begin
      if (stackTop != '0) stackTop   <= stackTop - 1'b1;  // pop a freed number
      else                allocCount <= allocCount + 1'b1;
    end else if (releaseEn) begin
      stackTop <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseEn) freedStack[stackTop[arrayNumW-1:0]] <= releaseNum;
  end

  assert property (@(posedge clock) disable iff (rst)
    allocate |-> (stackTop != '0 || allocCount < arrayCount))
    else $error("allocation beyond arrayCount");
  assert property (@(posedge clock) disable iff (rst) releaseEn |-> stackTop < arrayCount)
    else $error("release into a full freed stack");

endmodule

/* src/arrayMachine.sv */
//--------------------
// Array machine top level
// one instruction per clock from a preloaded code store
//--------------------
`timescale 1ns/100ps

module arrayMachine (
  input  logic                     clock,
  input  logic                     rst,
  input  logic                     load,
  input  machinePkg::codeAddr_t    loadAddr,
  input  machinePkg::instruction_t loadWord,
  input  logic                     run,
  output logic                     outValid,
  output machinePkg::word_t        outValue,
  output logic                     finished
);
  import machinePkg::*;

  instruction_t instruction;
  logic         active;
  resolved_t    targetRes;
  resolved_t    source1Res;
  resolved_t    source2Res;
  localImage_t  localImage;
  heapImage_t   heapImage;
  sizeImage_t   sizes;
  memWrite_t    memWrite;
  logic         resize;
  arrayNum_t    resizeArray;
  word_t        resizeValue;
  logic         jump;
  area_t        jumpOffset;
  logic         allocate;
  logic         releaseEn;
  arrayNum_t    releaseNum;
  arrayNum_t    grant;

  fetchUnit fetch (
    .clock, .rst, .load, .loadAddr, .loadWord, .run,
    .jump, .jumpOffset,
    .instruction, .active, .finished
  );

  //--------------------
  // operand resolution, one per field
  operandResolver targetResolver (
    .operand(instruction.target), .localImage, .heapImage, .resolved(targetRes)
  );
  operandResolver source1Resolver (
    .operand(instruction.source1), .localImage, .heapImage, .resolved(source1Res)
  );
  operandResolver source2Resolver (
    .operand(instruction.source2), .localImage, .heapImage, .resolved(source2Res)
  );

  executeUnit execute (
    .clock, .rst, .active,
    .opcode(instruction.opcode),
    .target(targetRes), .source1(source1Res), .source2(source2Res),
    .sizes, .grant,
    .memWrite, .resize, .resizeArray, .resizeValue,
    .jump, .jumpOffset,
    .allocate, .releaseEn, .releaseNum,
    .outValid, .outValue
  );

  dataMemory memory (
    .clock, .rst, .memWrite, .resize, .resizeArray, .resizeValue,
    .clearSize(allocate),                            // new array starts empty
    .clearArray(grant),
    .localImage, .heapImage, .sizes
  );

  arrayAllocator allocator (
    .clock, .rst, .allocate, .releaseEn, .releaseNum, .grant
  );

endmodule

/* src/dataMemory.sv */
//--------------------
// Data memory
// local memory, heap and array sizes behind one write port
//--------------------
`timescale 1ns/100ps

module dataMemory (
  input  logic                    clock,
  input  logic                    rst,
  input  machinePkg::memWrite_t   memWrite,
  input  logic                    resize,
  input  machinePkg::arrayNum_t   resizeArray,
  input  machinePkg::word_t       resizeValue,
  input  logic                    clearSize,
  input  machinePkg::arrayNum_t   clearArray,
  output machinePkg::localImage_t localImage,
  output machinePkg::heapImage_t  heapImage,
  output machinePkg::sizeImage_t  sizes
);
  import machinePkg::*;

  word_t curSize;
  word_t grownSize;
  logic  heapWrite;
  logic  localWrite;

  assign curSize    = sizes[memWrite.arrayNum];
  assign grownSize  = memWrite.index + 16'sd1;       // highest index plus one
  assign heapWrite  = memWrite.enable && (memWrite.arena == arenaHeap);
  assign localWrite = memWrite.enable && (memWrite.arena == arenaLocal);

  always_ff @(posedge clock) begin
    if (rst) begin
      localImage <= '0;
      heapImage  <= '0;
      sizes      <= '0;
    end else begin
      if (localWrite) begin
        localImage[memWrite.localLoc] <= memWrite.data;
      end
      if (heapWrite) begin
        heapImage[memWrite.heapLoc] <= memWrite.data;
        if (grownSize > curSize) sizes[memWrite.arrayNum] <= grownSize;
      end
      if (resize) begin
        sizes[resizeArray] <= resizeValue;
      end
      // later assignment wins, so a fresh array always reads size 0
      if (clearSize) begin
        sizes[clearArray] <= '0;
      end
    end
  end

endmodule

/* src/fetchUnit.sv */
//--------------------
// Fetch unit
// code store, program end, instruction pointer and finish flag
//--------------------
`timescale 1ns/100ps

module fetchUnit (
  input  logic                     clock,
  input  logic                     rst,
  input  logic                     load,
  input  machinePkg::codeAddr_t    loadAddr,
  input  machinePkg::instruction_t loadWord,
  input  logic                     run,
  input  logic                     jump,
  input  machinePkg::area_t        jumpOffset,
  output machinePkg::instruction_t instruction,
  output logic                     active,
  output logic                     finished
);
  import machinePkg::*;

  instruction_t       codeStore [codeSize];
  logic [codeAddrW:0] ip;                            // extra bit to point past the end
  logic [codeAddrW:0] progEnd;
  logic [codeAddrW:0] loadNext;

  assign loadNext    = {1'b0, loadAddr} + 1'b1;
  assign active      = run && (ip < progEnd);
  assign instruction = codeStore[ip[codeAddrW-1:0]];

  always_ff @(posedge clock) begin
    if (!run && load) begin
      codeStore[loadAddr] <= loadWord;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      ip       <= '0;
      progEnd  <= '0;
      finished <= 1'b0;
    end else if (!run) begin                         // idle, code may be loaded
      ip       <= '0;
      finished <= 1'b0;
      if (load && loadNext > progEnd) progEnd <= loadNext;
    end else if (active) begin
      ip <= jump ? ip + jumpOffset[codeAddrW:0] : ip + 1'b1;  // offset wraps with ip
    end else begin
      finished <= 1'b1;                              // held until run falls
    end
  end

  // only a jump can carry the pointer past the code store
  assert property (@(posedge clock) disable iff (rst) ip <= codeSize)
    else $error("instruction pointer %0d beyond code store", ip);

endmodule

/* verif/machinePrograms.svh */
//--------------------
// Test programs
// instruction assembly and one task per program
//--------------------
`ifndef MACHINE_PROGRAMS_SVH
`define MACHINE_PROGRAMS_SVH

function automatic operand_t opnd(arena_t arenaSel, areaMode_t areaSel, int areaVal,
                                  addrMode_t addrSel, int addrVal, int deltaVal);
  return '{area: area_t'(areaVal), address: area_t'(addrVal), arena: arenaSel,
           areaMode: areaSel, addrMode: addrSel, delta: 4'(deltaVal), spare: '0};
endfunction

function automatic operand_t lit(int value);       // constant
  return opnd(arenaLocal, areaDirect, 0, addrConst, value, 0);
endfunction

function automatic operand_t loc(int address);     // local[address]
  return opnd(arenaLocal, areaDirect, 0, addrDirect, address, 0);
endfunction

function automatic operand_t hop(int offset);      // jump step in the area field
  return opnd(arenaNone, areaDirect, offset, addrConst, 0, 0);
endfunction

task automatic storeInstr(opcode_t op, operand_t target, operand_t source1, operand_t source2);
  @(negedge clock);
  load     = 1'b1;
  loadAddr = codeAddr_t'(slot);
  loadWord = '{op, target, source1, source2};
  slot++;
endtask

task automatic expectOut(int value);
  expectQ.push_back(word_t'(value));
  refreshHead();
endtask

task automatic emitOut(operand_t source, int value);
  storeInstr(opOut, '0, source, '0);
  expectOut(value);
endtask

task automatic jumpOverOut(opcode_t op, operand_t source1, operand_t source2, bit taken,
                           int marker);
  storeInstr(op, hop(2), source1, source2);
  storeInstr(opOut, '0, lit(marker), '0);
  if (!taken) expectOut(marker);                   // marker only shows when not skipped
endtask

task automatic arithmeticTest();
  int    a;
  int    b;
  int    s;
  word_t shifted;
  testName = "arithmetic";
  applyReset();
  a = int'($urandom_range(200)) - 100;
  b = int'($urandom_range(200)) - 100;
  s = int'($urandom_range(4, 1));
  storeInstr(opMov, loc(0), lit(a), '0);
  storeInstr(opMov, loc(1), lit(b), '0);
  storeInstr(opMov, loc(2), lit(s), '0);
  storeInstr(opMov, loc(3), lit(1), '0);           // pointer to local 1
  storeInstr(opAdd, loc(4), loc(0), loc(1));
  emitOut(loc(4), a + b);
  storeInstr(opSubtract, loc(4), lit(a), opnd(arenaLocal, areaDirect, 0, addrIndirect, 3, 0));
  emitOut(loc(4), a - b);
  storeInstr(opNot, loc(5), loc(0), '0);
  emitOut(loc(5), a == 0);
  // shift count read through the pointer plus delta 1, so local 2
  storeInstr(opShiftLeft, loc(0), opnd(arenaLocal, areaDirect, 0, addrIndirect, 3, 1), '0);
  emitOut(loc(0), a << s);
  storeInstr(opShiftRight, loc(1), lit(s), '0);
  shifted = word_t'(b);
  shifted = shifted >> s;                          // zero fill
  emitOut(loc(1), shifted);
  runProgram();
endtask

task automatic heapTest();
  int c1;
  int c2;
  testName = "heap";
  applyReset();
  c1 = int'($urandom_range(200)) - 100;
  c2 = int'($urandom_range(200)) - 100;
  storeInstr(opMov, loc(0), lit(2), '0);           // array number for the indirect area
  storeInstr(opMov, opnd(arenaHeap, areaDirect, 2, addrDirect, 0, 1), lit(c1), '0);
  storeInstr(opMov, opnd(arenaHeap, areaIndirect, 0, addrDirect, 1, 1), lit(c2), '0);
  emitOut(opnd(arenaHeap, areaDirect, 2, addrDirect, 1, 0), c1);
  emitOut(opnd(arenaHeap, areaIndirect, 0, addrDirect, 2, 0), c2);
  storeInstr(opArraySize, loc(1), lit(2), '0);
  emitOut(loc(1), 3);                              // highest index 2 plus one
  storeInstr(opResize, opnd(arenaHeap, areaDirect, 2, addrConst, 0, 0), lit(7), '0);
  storeInstr(opArraySize, loc(1), lit(2), '0);
  emitOut(loc(1), 7);
  runProgram();
endtask

task automatic allocationTest();
  testName = "allocation";
  applyReset();
  storeInstr(opArray, loc(0), '0, '0);
  storeInstr(opArray, loc(1), '0, '0);
  storeInstr(opArray, loc(2), '0, '0);
  storeInstr(opMov, opnd(arenaHeap, areaIndirect, 1, addrDirect, 0, 0), lit(5), '0);
  storeInstr(opFree, loc(1), '0, '0);              // array 1 back on the stack
  storeInstr(opArray, loc(3), '0, '0);
  storeInstr(opArraySize, loc(4), loc(3), '0);
  emitOut(loc(0), 0);
  emitOut(loc(1), 1);
  emitOut(loc(2), 2);
  emitOut(loc(3), 1);
  emitOut(loc(4), 0);                              // reused array starts empty
  runProgram();
endtask

task automatic loopTest();
  int n;
  int k;
  testName = "countdown loop";
  applyReset();
  n = int'($urandom_range(6, 3));
  storeInstr(opMov, loc(0), lit(n), '0);
  storeInstr(opOut, '0, loc(0), '0);
  storeInstr(opSubtract, loc(0), loc(0), lit(1));
  storeInstr(opJNe, hop(-2), loc(0), lit(0));      // back to the out
  for (k = n; k >= 1; k--) expectOut(k);
  runProgram();
endtask

task automatic branchTest();
  int x;
  int y;
  testName = "forward jumps";
  applyReset();
  x = int'($urandom_range(100)) - 50;
  y = int'($urandom_range(100)) - 50;
  jumpOverOut(opJLt, lit(x), lit(y), x < y, 11);
  jumpOverOut(opJGe, lit(x), lit(y), x >= y, 12);
  jumpOverOut(opJTrue, lit(x), '0, x != 0, 13);
  jumpOverOut(opJFalse, lit(x), '0, x == 0, 14);
  jumpOverOut(opJmp, '0, '0, 1'b1, 15);
  emitOut(lit(16), 16);
  runProgram();
endtask

task automatic restartTest();
  int k;
  testName = "finish and restart";
  applyReset();
  k = int'($urandom_range(100));
  emitOut(lit(k), k);
  storeInstr(opAdd, loc(0), loc(0), lit(3));
  emitOut(loc(0), 3);
  storeInstr(opMov, opnd(arenaHeap, areaDirect, 0, addrDirect, 2, 0), lit(k), '0);
  storeInstr(opArraySize, loc(1), lit(0), '0);
  emitOut(loc(1), 3);
  runProgram();
  stopRun();
  expectOut(k);
  expectOut(6);                                    // local 0 kept its value
  expectOut(3);
  runProgram();
  applyReset();                                    // finished still high here
  storeInstr(opArraySize, loc(1), lit(0), '0);
  emitOut(loc(1), 0);
  emitOut(loc(0), 0);
  runProgram();
endtask

`endif

/* verif/arrayMachineTb.sv */
//--------------------
// Array machine testbench
// loads each test program, runs it and checks every out value
//--------------------
`timescale 1ns/100ps

module arrayMachineTb;
  import machinePkg::*;

  localparam int clockPeriod   = 100;
  localparam int resetCycles   = 5;
  localparam int testCount     = 6;
  localparam int cyclesPerTest = 200;              // also the per-program wait limit

  logic         clock;
  logic         rst;
  logic         load;
  codeAddr_t    loadAddr;
  instruction_t loadWord;
  logic         run;
  logic         outValid;
  word_t        outValue;
  logic         finished;

  word_t expectQ [$];                              // out values still to come
  word_t expectHead;
  logic  expectAny;
  int    valueErrors;
  int    otherErrors;
  int    slot;                                     // next code slot to load
  string testName;

  arrayMachine dut (.*);

  always #(clockPeriod / 2) clock = ~clock;

  //--------------------
  // out checking
  always @(posedge clock) begin
    if (outValid && expectQ.size() != 0) begin     // pulse was checked at the last negedge
      void'(expectQ.pop_front());
      refreshHead();
    end
  end

  assert property (@(negedge clock) outValid |-> expectAny)
    else begin
      otherErrors++;
      $display("%s: out value %0d arrived when none was expected", testName, outValue);
    end

  assert property (@(negedge clock) outValid && expectAny |-> outValue == expectHead)
    else begin
      valueErrors++;
      $display("Error in %s: expected %0d, actual %0d", testName, expectHead, outValue);
    end

  assert property (@(negedge clock) finished |-> !outValid)
    else begin
      otherErrors++;
      $display("%s: out strobe raised after the program finished", testName);
    end

  task automatic refreshHead();
    expectAny  = expectQ.size() != 0;
    expectHead = expectAny ? expectQ[0] : '0;
  endtask

  //--------------------
  // run control
  task automatic applyReset();
    @(negedge clock);
    rst  = 1'b1;
    load = 1'b0;
    @(negedge clock);                              // run still high for the first reset edge
    assert (!finished)
      else begin
        otherErrors++;
        $display("%s: finished stayed high through reset", testName);
      end
    run  = 1'b0;
    repeat (resetCycles - 1) @(negedge clock);
    rst  = 1'b0;
    slot = 0;
    expectQ.delete();
    refreshHead();
    assert (!finished && !outValid)
      else begin
        otherErrors++;
        $display("%s: finished or out strobe still high after reset", testName);
      end
  endtask

  task automatic runProgram();
    int waited;
    @(negedge clock);
    load   = 1'b0;
    run    = 1'b1;
    waited = 0;
    while (!finished && waited < cyclesPerTest) begin
      @(negedge clock);
      waited++;
    end
    assert (finished)
      else begin
        otherErrors++;
        $display("%s: program did not finish within %0d cycles", testName, cyclesPerTest);
      end
    assert (expectQ.size() == 0)
      else begin
        otherErrors++;
        $display("%s: %0d expected out values never appeared", testName, expectQ.size());
      end
    repeat (3) begin                               // finished holds while run is high
      @(negedge clock);
      assert (finished)
        else begin
          otherErrors++;
          $display("%s: finished dropped while run was still high", testName);
        end
    end
  endtask

  task automatic stopRun();
    @(negedge clock);
    run = 1'b0;
    @(negedge clock);
    assert (!finished)
      else begin
        otherErrors++;
        $display("%s: finished stayed high after run fell", testName);
      end
  endtask

  `include "machinePrograms.svh"

  //--------------------
  // watchdog
  initial begin
    #(testCount * cyclesPerTest * clockPeriod);
    $display("watchdog expired before all tests completed");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(86606));
    clock       = 1'b0;
    rst         = 1'b1;
    load        = 1'b0;
    loadAddr    = '0;
    loadWord    = '0;
    run         = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    testName    = "reset";
    refreshHead();
    applyReset();
    arithmeticTest();
    heapTest();
    allocationTest();
    loopTest();
    branchTest();
    restartTest();
    $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
